// ==== src.f ====
src/i3c_pkg.sv
src/i3c_ctrl_if.sv
src/wb_cmd_regs.sv
src/enthdr_engine.sv
src/sdr_serializer.sv
src/ccc_status.sv
src/i3c_ccc_top.sv
sim/i3c_ccc_properties.sv
sim/tb_i3c_ccc.sv

// ==== Makefile ====
# Verilator build for the broadcast CCC testbench

VERILATOR ?= verilator
TOP       ?= tb_i3c_ccc
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUNFLAGS  ?=

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_i3c_ccc.sv ====
module tb_i3c_ccc;

  logic       i_clk;
  logic       i_rst_n;
  logic       i_wb_cyc;
  logic       i_wb_stb;
  logic       i_wb_we;
  logic [1:0] i_wb_adr;
  logic [7:0] i_wb_dat;
  logic [7:0] o_wb_dat;
  logic       o_wb_ack;
  logic       o_scl;
  logic       o_sda_oe;
  logic       i_sda;
  logic       o_irq;
  logic       ack_enable;         // target answers the header
  int         tgt_rises;          // scl rises seen by the target
  int         err_cnt;
  logic [31:0] lcg_state;
  logic [31:0] rnd;
  logic [2:0]  mode;

  i3c_ccc_top u_i3c_ccc_top (.*);

  initial i_clk = 1'b0;
  always #10 i_clk = !i_clk;

  // wired and of controller, target ack drive and pull-up
  // target holds sda low from the eighth scl fall to the end of the ninth bit
  assign i_sda = !(o_sda_oe ||
                   (ack_enable && (((tgt_rises == 8) && !o_scl) ||
                                   ((tgt_rises == 9) && o_scl))));

  always @(posedge o_scl)
    tgt_rises = tgt_rises + 1;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic wb_cycle(input logic we, input logic [1:0] adr, input logic [7:0] wdat,
                          output logic [7:0] rdat);
    int n;
    n = 0;
    @(posedge i_clk);
    #2;
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = adr;
    i_wb_dat = wdat;
    do
    begin
      @(posedge i_clk);
      #1;
      n++;
    end while (!o_wb_ack && n < 20);
    if (!o_wb_ack)
    begin
      err_cnt++;
      $display("timeout waiting for wishbone ack at %0t", $time);
    end
    rdat = o_wb_dat;
    #1;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [7:0] wdat);
    logic [7:0] unused;
    wb_cycle(1'b1, adr, wdat, unused);
  endtask

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_status(input logic [7:0] exp);
    logic [7:0] got;
    wb_cycle(1'b0, i3c_pkg::REG_STATUS, 8'h00, got);
    check_value("status", got, exp);
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    while ((o_irq !== level) && n < 2000)
    begin
      @(posedge i_clk);
      #1;
      n++;
    end
    if (o_irq !== level)
    begin
      err_cnt++;
      $display("timeout waiting for irq %s at %0t", level ? "high" : "low", $time);
    end
  endtask

  task automatic begin_run(input logic ack);
    wb_write(i3c_pkg::REG_STATUS, 8'h00);   // clear sticky bits
    ack_enable = ack;
    tgt_rises  = 0;
  endtask

  initial
  begin
    i_rst_n    = 1'b0;
    i_wb_cyc   = 1'b0;
    i_wb_stb   = 1'b0;
    i_wb_we    = 1'b0;
    i_wb_adr   = 2'd0;
    i_wb_dat   = 8'h00;
    ack_enable = 1'b0;
    tgt_rises  = 0;
    err_cnt    = 0;
    lcg_state  = 32'he7859270;
    repeat (5) @(posedge i_clk);
    #2;
    i_rst_n = 1'b1;

    // successful enthdr runs with a second start while busy
    repeat (3)
    begin
      rnd  = lcg_next();
      mode = rnd[18:16];
      begin_run(1'b1);
      wb_write(i3c_pkg::REG_CCC, {i3c_pkg::ENTHDR_MASK, mode});
      wb_write(i3c_pkg::REG_CTRL, 8'h01);
      wb_write(i3c_pkg::REG_CTRL, 8'h01);
      wait_irq(1'b1);
      check_status({mode, 5'b10010});
      check_value("scl_rises", 8'(tgt_rises), 8'd18);
      check_value("o_irq", {7'd0, o_irq}, 8'd1);
      wb_write(i3c_pkg::REG_STATUS, 8'h00);
      wait_irq(1'b0);
      check_status({mode, 5'b10000});
      wb_write(i3c_pkg::REG_CTRL, 8'h02);    // hdr exit
      check_status({mode, 5'b00000});
    end

    // nobody acks the header
    begin_run(1'b0);
    wb_write(i3c_pkg::REG_CTRL, 8'h01);
    wait_irq(1'b1);
    repeat (40) @(posedge i_clk);
    check_status({mode, 5'b00100});
    check_value("scl_rises", 8'(tgt_rises), 8'd9);

    // header with rnw set
    begin_run(1'b1);
    wb_write(i3c_pkg::REG_HDR, 8'hFD);
    wb_write(i3c_pkg::REG_CTRL, 8'h01);
    wait_irq(1'b1);
    check_status({mode, 5'b01000});
    check_value("scl_rises", 8'(tgt_rises), 8'd0);
    wb_write(i3c_pkg::REG_HDR, i3c_pkg::BCAST_HDR_RST);

    // code outside the enthdr family
    begin_run(1'b1);
    wb_write(i3c_pkg::REG_CCC, 8'h40);
    wb_write(i3c_pkg::REG_CTRL, 8'h01);
    wait_irq(1'b1);
    repeat (40) @(posedge i_clk);
    check_status({mode, 5'b01000});
    check_value("scl_rises", 8'(tgt_rises), 8'd9);
    wb_write(i3c_pkg::REG_STATUS, 8'h00);

    repeat (5) @(posedge i_clk);
    $display("errors: %0d, assertion failures: %0d", err_cnt, u_i3c_ccc_top.u_props.fail_cnt);
    if ((err_cnt == 0) && (u_i3c_ccc_top.u_props.fail_cnt == 0))
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== sim/i3c_ccc_properties.sv ====
module i3c_ccc_properties (
  input logic                 i_clk,
  input logic                 i_rst_n,
  input logic                 i_wb_cyc,
  input logic                 i_wb_stb,
  input logic                 i_wb_ack,
  input logic                 i_scl,
  input logic                 i_sda,
  input logic                 i_busy,
  input logic [7:0]           i_status,
  input i3c_pkg::frame_byte_u i_hdr_entry,
  input i3c_pkg::frame_byte_u i_ccc_entry
);

  int         fail_cnt = 0;   // read by the testbench summary
  logic       scl_d;
  logic       scl_rise;
  logic [4:0] rise_cnt;       // scl rises in the current transaction
  logic [8:0] sda_sh;         // sda taken at each scl rise

  assign scl_rise = i_scl && !scl_d;

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      scl_d    <= 1'b0;
      rise_cnt <= 5'd0;
      sda_sh   <= 9'd0;
    end
    else
    begin
      scl_d <= i_scl;
      if (!i_busy)
        rise_cnt <= 5'd0;     // new count per transaction
      else if (scl_rise)
        rise_cnt <= rise_cnt + 5'd1;
      if (scl_rise)
        sda_sh <= {sda_sh[7:0], i_sda};
    end
  end

  a_ack_follows_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_wb_cyc && i_wb_stb && !i_wb_ack |=> i_wb_ack)
    else begin fail_cnt++; $error("wishbone ack missing after request"); end

  a_ack_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_wb_ack |=> !i_wb_ack)
    else begin fail_cnt++; $error("wishbone ack longer than one cycle"); end

  a_no_ack_without_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
    else begin fail_cnt++; $error("wishbone ack without cyc and stb"); end

  a_header_bits: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    scl_rise && (rise_cnt == 5'd7) |=> (sda_sh[7:0] == i_hdr_entry))
    else begin fail_cnt++; $error("header bits differ from table entry"); end

  a_code_bits: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    scl_rise && (rise_cnt == 5'd17) |=> (sda_sh[8:1] == i_ccc_entry) && (^sda_sh == 1'b1))
    else begin fail_cnt++; $error("code bits or odd parity t bit wrong"); end

  a_scl_only_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $changed(i_scl) |-> i_busy)
    else begin fail_cnt++; $error("scl toggled while idle"); end

  a_max_rises: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    scl_rise |-> (rise_cnt < 5'd18))
    else begin fail_cnt++; $error("more than 18 scl rises in one transaction"); end

  a_done_rises: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_status[1]) |-> (rise_cnt == 5'd18))
    else begin fail_cnt++; $error("done without exactly 18 scl rises"); end

  a_nack_rises: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(i_status[2]) |-> (rise_cnt == 5'd9) && !i_status[4])
    else begin fail_cnt++; $error("nack after wrong bit count or with hdr active"); end

  // after nack or err the bus stays quiet until the status is cleared
  a_quiet_after_fail: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_status[2] || i_status[3]) |-> !scl_rise)
    else begin fail_cnt++; $error("scl rise after nack or err"); end

endmodule

bind i3c_ccc_top i3c_ccc_properties u_props (
  .i_clk       (i_clk),
  .i_rst_n     (i_rst_n),
  .i_wb_cyc    (i_wb_cyc),
  .i_wb_stb    (i_wb_stb),
  .i_wb_ack    (o_wb_ack),
  .i_scl       (o_scl),
  .i_sda       (i_sda),
  .i_busy      (busy),
  .i_status    (status),
  .i_hdr_entry (hdr_entry),
  .i_ccc_entry (ccc_entry)
);

// ==== src/i3c_ccc_top.sv ====
module i3c_ccc_top (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_wb_cyc,
  input  logic       i_wb_stb,
  input  logic       i_wb_we,
  input  logic [1:0] i_wb_adr,
  input  logic [7:0] i_wb_dat,
  output logic [7:0] o_wb_dat,
  output logic       o_wb_ack,
  output logic       o_scl,
  output logic       o_sda_oe,
  input  logic       i_sda,
  output logic       o_irq
);

  logic                 start;
  logic                 hdr_exit;
  logic                 clr;
  logic                 busy;
  logic                 busy_set;
  logic                 done;
  logic                 nack;
  logic                 err;
  logic [2:0]           mode;
  logic [7:0]           status;
  i3c_pkg::frame_byte_u hdr_entry;
  i3c_pkg::frame_byte_u ccc_entry;

  i3c_ctrl_if u_ctrl_if ();   // engine <-> serializer handshake

  wb_cmd_regs u_wb_cmd_regs (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .i_wb_we     (i_wb_we),
    .i_wb_adr    (i_wb_adr),
    .i_wb_dat    (i_wb_dat),
    .o_wb_dat    (o_wb_dat),
    .o_wb_ack    (o_wb_ack),
    .i_busy      (busy),
    .i_status    (status),
    .o_start     (start),
    .o_exit      (hdr_exit),
    .o_clr       (clr),
    .o_hdr_entry (hdr_entry),
    .o_ccc_entry (ccc_entry)
  );

  enthdr_engine u_enthdr_engine (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_start     (start),
    .i_hdr_entry (hdr_entry),
    .i_ccc_entry (ccc_entry),
    .ctrl        (u_ctrl_if.engine),
    .o_done      (done),
    .o_nack      (nack),
    .o_err       (err),
    .o_mode      (mode),
    .o_busy_set  (busy_set)
  );

  sdr_serializer u_sdr_serializer (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .ctrl     (u_ctrl_if.phy),
    .o_scl    (o_scl),
    .o_sda_oe (o_sda_oe),
    .i_sda    (i_sda)
  );

  ccc_status u_ccc_status (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_busy_set (busy_set),
    .i_done     (done),
    .i_nack     (nack),
    .i_err      (err),
    .i_mode     (mode),
    .i_clr      (clr),
    .i_exit     (hdr_exit),
    .o_busy     (busy),
    .o_status   (status),
    .o_irq      (o_irq)
  );

endmodule

// ==== src/ccc_status.sv ====
module ccc_status (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_busy_set,
  input  logic       i_done,
  input  logic       i_nack,
  input  logic       i_err,
  input  logic [2:0] i_mode,
  input  logic       i_clr,      // status write
  input  logic       i_exit,     // ctrl exit write
  output logic       o_busy,
  output logic [7:0] o_status,
  output logic       o_irq
);

  logic       busy_q;
  logic       done_q;
  logic       nack_q;
  logic       err_q;
  logic       hdr_active_q;
  logic [2:0] mode_q;

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      busy_q       <= 1'b0;
      done_q       <= 1'b0;
      nack_q       <= 1'b0;
      err_q        <= 1'b0;
      hdr_active_q <= 1'b0;
      mode_q       <= 3'd0;
    end
    else
    begin
      if (i_done || i_nack || i_err)
        busy_q <= 1'b0;                       // any end event
      else if (i_busy_set)
        busy_q <= 1'b1;
      done_q <= i_done || (done_q && !i_clr);   // sticky until cleared
      nack_q <= i_nack || (nack_q && !i_clr);
      err_q  <= i_err  || (err_q  && !i_clr);
      if (i_done)
      begin
        hdr_active_q <= 1'b1;                 // bus now in hdr mode
        mode_q       <= i_mode;
      end
      else if (i_exit)
        hdr_active_q <= 1'b0;
    end
  end

  always_comb
  begin
    o_status                                = 8'h00;
    o_status[i3c_pkg::STAT_BUSY_BIT]        = busy_q;
    o_status[i3c_pkg::STAT_DONE_BIT]        = done_q;
    o_status[i3c_pkg::STAT_NACK_BIT]        = nack_q;
    o_status[i3c_pkg::STAT_ERR_BIT]         = err_q;
    o_status[i3c_pkg::STAT_HDR_BIT]         = hdr_active_q;
    o_status[i3c_pkg::STAT_MODE_LSB +: 3]   = mode_q;
  end

  assign o_busy = busy_q;
  assign o_irq  = done_q || nack_q || err_q;   // level irq

endmodule

// ==== src/sdr_serializer.sv ====
module sdr_serializer (
  input  logic     i_clk,
  input  logic     i_rst_n,
  i3c_ctrl_if.phy  ctrl,
  output logic     o_scl,     // push-pull, idles low
  output logic     o_sda_oe,  // 1 pulls sda low
  input  logic     i_sda      // resolved line
);

  logic       active_q;
  logic       ack_q;          // current job is the ack bit
  logic       tbit_q;         // parity bit appended
  logic       scl_q;
  logic       sda_oe_q;
  logic       nack_q;
  logic [2:0] half_cnt;
  logic [3:0] bit_cnt;        // index of the bit on the line
  logic [8:0] shift_q;        // {byte, t}
  logic       half_end;
  logic       last_bit;
  logic       byte_end;
  logic       load;

  assign load     = !active_q && (ctrl.tx_start || ctrl.ack_start);
  assign half_end = active_q && (half_cnt == (i3c_pkg::SCL_HALF - 3'd1));
  assign last_bit = ack_q || (bit_cnt == (tbit_q ? 4'd8 : 4'd7));
  assign byte_end = !ack_q && ((bit_cnt == 4'd7) || (bit_cnt == 4'd8));   // byte or t bit out

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      active_q      <= 1'b0;
      ack_q         <= 1'b0;
      tbit_q        <= 1'b0;
      scl_q         <= 1'b0;
      sda_oe_q      <= 1'b0;
      nack_q        <= 1'b0;
      half_cnt      <= 3'd0;
      bit_cnt       <= 4'd0;
      ctrl.tx_done  <= 1'b0;
      ctrl.ack_done <= 1'b0;
    end
    else
    begin
      ctrl.tx_done  <= 1'b0;
      ctrl.ack_done <= 1'b0;
      if (load)
      begin
        active_q <= 1'b1;
        ack_q    <= ctrl.ack_start;
        tbit_q   <= ctrl.tx_start && ctrl.tx_tbit;
        half_cnt <= 3'd0;
        bit_cnt  <= 4'd0;
        sda_oe_q <= ctrl.tx_start && !ctrl.tx_byte[7];   // first bit set while scl low
      end
      else if (half_end)
      begin
        half_cnt <= 3'd0;
        scl_q    <= !scl_q;
        if (!scl_q && ack_q)
          nack_q <= i_sda;          // taken as scl rises, low = ack
        if (scl_q)                  // falling edge closes the bit
        begin
          ctrl.tx_done  <= byte_end;
          ctrl.ack_done <= ack_q;
          if (last_bit)
          begin
            active_q <= 1'b0;
            sda_oe_q <= 1'b0;       // release line
          end
          else
          begin
            bit_cnt  <= bit_cnt + 4'd1;
            sda_oe_q <= !shift_q[7];   // next bit, scl now low
          end
        end
      end
      else if (active_q)
        half_cnt <= half_cnt + 3'd1;
    end
  end

  // data shifter, msb first, odd parity as ninth bit
  always_ff @(posedge i_clk)
  begin
    if (load && ctrl.tx_start)
      shift_q <= {ctrl.tx_byte, ~^ctrl.tx_byte};
    else if (half_end && scl_q && !last_bit)
      shift_q <= {shift_q[7:0], 1'b0};
  end

  assign o_scl         = scl_q;
  assign o_sda_oe      = sda_oe_q;
  assign ctrl.ack_nack = nack_q;

endmodule

// ==== src/enthdr_engine.sv ====
module enthdr_engine (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_start,       // pulse from ctrl write
  input  i3c_pkg::frame_byte_u i_hdr_entry,
  input  i3c_pkg::frame_byte_u i_ccc_entry,
  i3c_ctrl_if.engine           ctrl,
  output logic                 o_done,
  output logic                 o_nack,
  output logic                 o_err,
  output logic [2:0]           o_mode,
  output logic                 o_busy_set
);

  i3c_pkg::eng_state_e  state;
  i3c_pkg::frame_byte_u cur_q;       // byte being sent, header then code
  logic                 err_q;
  logic                 start_ok;

  assign start_ok   = i_start && (state == i3c_pkg::IDLE);
  assign o_busy_set = start_ok && !i_hdr_entry.hdr.rnw;   // valid write header only
  assign o_err      = err_q || (start_ok && i_hdr_entry.hdr.rnw);   // rnw err, no bus activity
  assign ctrl.tx_byte = cur_q;

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      state          <= i3c_pkg::IDLE;
      ctrl.tx_start  <= 1'b0;
      ctrl.tx_tbit   <= 1'b0;
      ctrl.ack_start <= 1'b0;
      o_done         <= 1'b0;
      o_nack         <= 1'b0;
      err_q          <= 1'b0;
      o_mode         <= 3'd0;
    end
    else
    begin
      ctrl.tx_start  <= 1'b0;        // pulses default low
      ctrl.ack_start <= 1'b0;
      o_done         <= 1'b0;
      o_nack         <= 1'b0;
      err_q          <= 1'b0;
      case (state)
        i3c_pkg::IDLE:
        begin
          if (o_busy_set)
          begin
            ctrl.tx_start <= 1'b1;   // 7'h7E + w, no parity bit
            ctrl.tx_tbit  <= 1'b0;
            state         <= i3c_pkg::HEADER;
          end
        end
        i3c_pkg::HEADER:
        begin
          if (ctrl.tx_done)
          begin
            ctrl.ack_start <= 1'b1;
            state          <= i3c_pkg::ACK;
          end
        end
        i3c_pkg::ACK:
        begin
          if (ctrl.ack_done)
          begin
            if (ctrl.ack_nack)
            begin
              o_nack <= 1'b1;        // nobody there, back off
              state  <= i3c_pkg::IDLE;
            end
            else if (i_ccc_entry.ccc.family != i3c_pkg::ENTHDR_MASK)
            begin
              err_q <= 1'b1;         // not an enthdr code, stop before code bits
              state <= i3c_pkg::IDLE;
            end
            else
            begin
              ctrl.tx_start <= 1'b1;
              ctrl.tx_tbit  <= 1'b1; // code then t bit, back to back
              state         <= i3c_pkg::CODE;
            end
          end
        end
        i3c_pkg::CODE:
        begin
          if (ctrl.tx_done)
            state <= i3c_pkg::TBIT;  // byte out, parity bit follows
        end
        i3c_pkg::TBIT:
        begin
          if (ctrl.tx_done)
          begin
            o_done <= 1'b1;
            o_mode <= cur_q.ccc.mode;
            state  <= i3c_pkg::IDLE;
          end
        end
        default: state <= i3c_pkg::IDLE;
      endcase
    end
  end

  // frame byte, header at start, code after ack
  always_ff @(posedge i_clk)
  begin
    if (o_busy_set)
      cur_q <= i_hdr_entry;
    else if ((state == i3c_pkg::ACK) && ctrl.ack_done)
      cur_q <= i_ccc_entry;
  end

endmodule

// ==== src/wb_cmd_regs.sv ====
module wb_cmd_regs (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  logic                 i_wb_cyc,
  input  logic                 i_wb_stb,
  input  logic                 i_wb_we,
  input  logic [1:0]           i_wb_adr,
  input  logic [7:0]           i_wb_dat,
  output logic [7:0]           o_wb_dat,
  output logic                 o_wb_ack,
  input  logic                 i_busy,      // from status block
  input  logic [7:0]           i_status,
  output logic                 o_start,
  output logic                 o_exit,
  output logic                 o_clr,
  output i3c_pkg::frame_byte_u o_hdr_entry,
  output i3c_pkg::frame_byte_u o_ccc_entry
);

  logic                 ack_q;
  logic                 req;
  logic                 wr;
  logic                 start_q;
  logic                 exit_q;
  logic                 clr_q;
  logic [7:0]           rdata_q;
  i3c_pkg::frame_byte_u hdr_q;             // broadcast header entry
  i3c_pkg::frame_byte_u ccc_q;             // ccc code entry

  assign req = i_wb_cyc && i_wb_stb && !ack_q;   // new classic cycle, ack not yet given
  assign wr  = req && i_wb_we;

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      ack_q   <= 1'b0;
      start_q <= 1'b0;
      exit_q  <= 1'b0;
      clr_q   <= 1'b0;
      rdata_q <= 8'h00;
      hdr_q   <= i3c_pkg::BCAST_HDR_RST;
      ccc_q   <= i3c_pkg::ENTHDR0_CODE;
    end
    else
    begin
      ack_q   <= req;                                             // one cycle ack
      start_q <= wr && (i_wb_adr == i3c_pkg::REG_CTRL) &&
                 i_wb_dat[i3c_pkg::CTRL_START_BIT] && !i_busy;   // dropped while busy
      exit_q  <= wr && (i_wb_adr == i3c_pkg::REG_CTRL) &&
                 i_wb_dat[i3c_pkg::CTRL_EXIT_BIT];
      clr_q   <= wr && (i_wb_adr == i3c_pkg::REG_STATUS);        // any data clears
      if (wr && (i_wb_adr == i3c_pkg::REG_HDR))
        hdr_q <= i_wb_dat;
      if (wr && (i_wb_adr == i3c_pkg::REG_CCC))
        ccc_q <= i_wb_dat;
      if (req && !i_wb_we)
      begin
        case (i_wb_adr)
          i3c_pkg::REG_STATUS: rdata_q <= i_status;
          i3c_pkg::REG_HDR:    rdata_q <= hdr_q;
          i3c_pkg::REG_CCC:    rdata_q <= ccc_q;
          default:             rdata_q <= 8'h00;   // ctrl is write only
        endcase
      end
    end
  end

  assign o_wb_ack    = ack_q;
  assign o_wb_dat    = rdata_q;    // valid together with ack
  assign o_start     = start_q;
  assign o_exit      = exit_q;
  assign o_clr       = clr_q;
  assign o_hdr_entry = hdr_q;
  assign o_ccc_entry = ccc_q;

endmodule

// ==== src/i3c_ctrl_if.sv ====
interface i3c_ctrl_if;

  logic       tx_start;   // pulse, load tx_byte and go
  logic [7:0] tx_byte;    // msb first on sda
  logic       tx_tbit;    // append odd parity after the byte
  logic       ack_start;  // pulse, one released bit and sample
  logic       tx_done;    // pulse at byte end and again at t bit end
  logic       ack_done;   // pulse when the ack bit ends
  logic       ack_nack;   // 1 = nack, valid with ack_done

  modport engine (
    output tx_start, tx_byte, tx_tbit, ack_start,
    input  tx_done, ack_done, ack_nack
  );

  modport phy (
    input  tx_start, tx_byte, tx_tbit, ack_start,
    output tx_done, ack_done, ack_nack
  );

endinterface

// ==== src/i3c_pkg.sv ====
package i3c_pkg;

  localparam logic [2:0] SCL_HALF      = 3'd4;      // clocks per scl half period
  localparam logic [7:0] BCAST_HDR_RST = 8'hFC;     // 7'h7E + write
  localparam logic [7:0] ENTHDR0_CODE  = 8'h20;     // enthdr0, hdr-ddr
  localparam logic [4:0] ENTHDR_MASK   = 5'b00100;  // code[7:3] of the enthdr family

  // word addresses on the wishbone side
  localparam logic [1:0] REG_CTRL   = 2'd0;
  localparam logic [1:0] REG_STATUS = 2'd1;
  localparam logic [1:0] REG_HDR    = 2'd2;
  localparam logic [1:0] REG_CCC    = 2'd3;

  localparam int CTRL_START_BIT = 0;   // kick one broadcast ccc
  localparam int CTRL_EXIT_BIT  = 1;   // host signals hdr exit done

  localparam int STAT_BUSY_BIT = 0;
  localparam int STAT_DONE_BIT = 1;
  localparam int STAT_NACK_BIT = 2;
  localparam int STAT_ERR_BIT  = 3;
  localparam int STAT_HDR_BIT  = 4;    // hdr_active
  localparam int STAT_MODE_LSB = 5;    // hdr_mode in bits 7:5

  typedef struct packed {
    logic [6:0] addr;                  // 7'h7E for broadcast
    logic       rnw;                   // must be 0 for a ccc
  } hdr_view_t;

  typedef struct packed {
    logic [4:0] family;                // upper code bits
    logic [2:0] mode;                  // enthdr index 0..7
  } ccc_view_t;

  // one table byte, read as a header or as a ccc code
  typedef union packed {
    hdr_view_t hdr;
    ccc_view_t ccc;
  } frame_byte_u;

  typedef enum logic [2:0] {IDLE, HEADER, ACK, CODE, TBIT} eng_state_e;

endpackage
